/* common/eeprom_pkg.sv */
package eeprom_pkg;

  localparam int ADDR_W    = 11;
  localparam int BLOCK_W   = 3;
  localparam int BYTE_W    = 8;
  localparam int BIT_CNT_W = 4;

  localparam logic [3:0] DEVICE_CODE = 4'b1010; // 24Cxx family code

  // two-bit level patterns, bit 1 goes out first
  localparam logic [1:0] START_PATTERN = 2'b10;
  localparam logic [1:0] STOP_PATTERN  = 2'b01;

  // condition steps in the line driver
  localparam logic [2:0] COND_IDLE  = 3'b000;
  localparam logic [2:0] COND_BEGIN = 3'b001;
  localparam logic [2:0] COND_LEVEL = 3'b010;
  localparam logic [2:0] COND_END   = 3'b100;

  typedef struct packed {
    logic [BYTE_W-BLOCK_W-2:0] device_code;
    logic [BLOCK_W-1:0]        block;     // address bits 10:8
    logic                      read_flag;
  } select_fields_t;

  typedef union packed {
    logic [BYTE_W-1:0] raw;
    select_fields_t    fields;
  } select_byte_u;

  typedef enum logic [9:0] {
    st_idle        = 10'b0000000001,
    st_write_start = 10'b0000000010,
    st_ctrl_write  = 10'b0000000100,
    st_addr_write  = 10'b0000001000,
    st_data_write  = 10'b0000010000,
    st_read_start  = 10'b0000100000,
    st_ctrl_read   = 10'b0001000000,
    st_data_read   = 10'b0010000000,
    st_stop        = 10'b0100000000,
    st_ack         = 10'b1000000000
  } seq_state_e;

endpackage

/* serial/byte_transmitter.sv */
module byte_transmitter
  import eeprom_pkg::*;
(
  input  logic              CLK,
  input  logic              RESET,
  input  logic              SCL,
  input  logic              tx_load,
  input  logic [BYTE_W-1:0] tx_byte,
  output logic              tx_bit,
  output logic              tx_done
);

  logic [BYTE_W-1:0]    shift_q;
  logic [BIT_CNT_W-1:0] bit_cnt;
  logic                 busy;
  logic                 shift_en;

  assign shift_en = busy && !SCL && !tx_load;
  assign tx_bit   = shift_q[BYTE_W-1]; // msb first

  always_ff @(posedge CLK)
  begin
    if (RESET)
    begin
      busy    <= 1'b0;
      bit_cnt <= '0;
      tx_done <= 1'b0;
    end
    else
    begin
      tx_done <= 1'b0;
      if (tx_load)
      begin
        busy    <= 1'b1;
        bit_cnt <= '0;
      end
      else if (shift_en)
      begin
        bit_cnt <= bit_cnt + 1'b1;
        // last shift leaves all ones, i.e. SDA released for the ack slot
        if (bit_cnt == BIT_CNT_W'(BYTE_W - 1))
        begin
          busy    <= 1'b0;
          tx_done <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge CLK)
  begin
    if (tx_load)
      shift_q <= tx_byte;
    else if (shift_en)
      shift_q <= {shift_q[BYTE_W-2:0], 1'b1}; // fill with ones
  end

endmodule

/* serial/byte_receiver.sv */
module byte_receiver
  import eeprom_pkg::*;
(
  input  logic              CLK,
  input  logic              RESET,
  input  logic              SCL,
  input  logic              SDA,
  input  logic              rx_start,
  output logic [BYTE_W-1:0] rx_byte,
  output logic              rx_done
);

  logic [BIT_CNT_W-1:0] bit_cnt;
  logic                 busy;
  logic                 sample_en;

  // the rx_start cycle is the begin step, sampling follows on SCL high
  assign sample_en = busy && SCL && !rx_start;

  always_ff @(posedge CLK)
  begin
    if (RESET)
    begin
      busy    <= 1'b0;
      bit_cnt <= '0;
      rx_done <= 1'b0;
    end
    else
    begin
      rx_done <= 1'b0;
      if (rx_start)
      begin
        busy    <= 1'b1;
        bit_cnt <= '0;
      end
      else if (sample_en)
      begin
        bit_cnt <= bit_cnt + 1'b1;
        if (bit_cnt == BIT_CNT_W'(BYTE_W - 1))
        begin
          busy    <= 1'b0;
          rx_done <= 1'b1; // byte complete
        end
      end
    end
  end

  always_ff @(posedge CLK)
  begin
    if (sample_en)
      rx_byte <= {rx_byte[BYTE_W-2:0], SDA};
  end

endmodule

/* serial/sda_line_driver.sv */
module sda_line_driver
  import eeprom_pkg::*;
(
  input  logic CLK,
  input  logic RESET,
  input  logic SCL,
  input  logic cond_start,
  input  logic cond_stop,
  input  logic tx_active,
  input  logic rx_active,
  input  logic tx_bit,
  output logic cond_done,
  inout  wire  SDA
);

  logic [2:0] cond_state;
  logic [1:0] pattern;
  logic       level_q;
  logic       cond_sel;   // condition level owns the line
  logic       tx_sel;     // transmit bit owns the line
  logic       sda_value;

  always_comb
  begin
    if (cond_sel)
      sda_value = level_q;
    else if (tx_sel && !rx_active)
      sda_value = tx_bit;
    else
      sda_value = 1'b1; // released
  end

  // open drain, a one is left to the pullup
  assign SDA = sda_value ? 1'bz : 1'b0;

  always_ff @(posedge CLK)
  begin
    if (RESET)
    begin
      cond_state <= COND_IDLE;
      pattern    <= START_PATTERN;
      level_q    <= 1'b1;
      cond_sel   <= 1'b0;
      tx_sel     <= 1'b0;
      cond_done  <= 1'b0;
    end
    else
    begin
      cond_done <= 1'b0;
      // line owner only switches while SCL is low
      if (!SCL)
        tx_sel <= tx_active;
      if (cond_start || cond_stop)
      begin
        pattern    <= cond_start ? START_PATTERN : STOP_PATTERN;
        cond_state <= COND_BEGIN;
      end
      else
      begin
        case (cond_state)
          COND_BEGIN:
            if (!SCL)
            begin
              level_q    <= pattern[1];
              cond_sel   <= 1'b1;
              cond_done  <= 1'b1; // next byte may load now
              cond_state <= COND_LEVEL;
            end
          COND_LEVEL:
            if (SCL)
            begin
              level_q    <= pattern[0]; // the actual start/stop edge
              cond_state <= COND_END;
            end
          COND_END:
            if (!SCL)
            begin
              cond_sel   <= 1'b0;
              cond_state <= COND_IDLE;
            end
          default:
            cond_state <= COND_IDLE;
        endcase
      end
    end
  end

endmodule

/* logic/eeprom_sequencer.sv */
module eeprom_sequencer
  import eeprom_pkg::*;
(
  input  logic              CLK,
  input  logic              RESET,
  input  logic              wr,
  input  logic              rd,
  input  logic [ADDR_W-1:0] addr,
  input  logic [BYTE_W-1:0] wdata,
  input  logic              cond_done,
  input  logic              tx_done,
  input  logic              rx_done,
  input  logic [BYTE_W-1:0] rx_byte,
  output logic              SCL,
  output logic              ack,
  output logic [BYTE_W-1:0] rdata,
  output logic              cond_start,
  output logic              cond_stop,
  output logic              tx_active,
  output logic              rx_active,
  output logic              tx_load,
  output logic [BYTE_W-1:0] tx_byte,
  output logic              rx_start
);

  seq_state_e   state;
  logic         is_read;  // latched request type
  select_byte_u sel_byte;

  // serial clock is CLK / 2, edges land between the posedges
  always_ff @(negedge CLK)
  begin
    if (RESET)
      SCL <= 1'b0;
    else
      SCL <= ~SCL;
  end

  // read flag only set for the select byte after the repeated start
  always_comb
  begin
    sel_byte.fields.device_code = DEVICE_CODE;
    sel_byte.fields.block       = addr[ADDR_W-1:BYTE_W];
    sel_byte.fields.read_flag   = (state == st_read_start);
  end

  always_ff @(posedge CLK)
  begin
    if (RESET)
    begin
      state      <= st_idle;
      is_read    <= 1'b0;
      ack        <= 1'b0;
      cond_start <= 1'b0;
      cond_stop  <= 1'b0;
      tx_active  <= 1'b0;
      rx_active  <= 1'b0;
      tx_load    <= 1'b0;
      tx_byte    <= '0;
      rx_start   <= 1'b0;
    end
    else
    begin
      cond_start <= 1'b0; // single cycle pulses
      cond_stop  <= 1'b0;
      tx_load    <= 1'b0;
      rx_start   <= 1'b0;
      unique case (state)
        st_idle:
        begin
          ack <= 1'b0;
          if (wr)
          begin
            is_read    <= 1'b0;
            cond_start <= 1'b1;
            state      <= st_write_start;
          end
          else if (rd)
          begin
            is_read    <= 1'b1;
            cond_start <= 1'b1;
            state      <= st_write_start;
          end
        end
        st_write_start:
          if (cond_done)
          begin
            tx_byte   <= sel_byte.raw;
            tx_load   <= 1'b1;
            tx_active <= 1'b1;
            state     <= st_ctrl_write;
          end
        st_ctrl_write:
          if (tx_done)
          begin
            tx_byte <= addr[BYTE_W-1:0]; // low address byte
            tx_load <= 1'b1;
            state   <= st_addr_write;
          end
        st_addr_write:
          if (tx_done)
          begin
            if (is_read)
            begin
              tx_active  <= 1'b0;
              cond_start <= 1'b1; // repeated start
              state      <= st_read_start;
            end
            else
            begin
              tx_byte <= wdata;
              tx_load <= 1'b1;
              state   <= st_data_write;
            end
          end
        st_data_write:
          if (tx_done)
          begin
            tx_active <= 1'b0;
            cond_stop <= 1'b1;
            state     <= st_stop;
          end
        st_read_start:
          if (cond_done)
          begin
            tx_byte   <= sel_byte.raw;
            tx_load   <= 1'b1;
            tx_active <= 1'b1;
            state     <= st_ctrl_read;
          end
        st_ctrl_read:
          if (tx_done)
          begin
            tx_active <= 1'b0;
            rx_active <= 1'b1; // SDA handed to the EEPROM
            rx_start  <= 1'b1;
            state     <= st_data_read;
          end
        st_data_read:
          if (rx_done)
          begin
            rx_active <= 1'b0;
            cond_stop <= 1'b1;
            state     <= st_stop;
          end
        st_stop:
          if (cond_done)
          begin
            ack   <= 1'b1;
            state <= st_ack;
          end
        st_ack:
        begin
          ack   <= 1'b0;
          state <= st_idle;
        end
      endcase
    end
  end

  // read byte kept until the next read completes
  always_ff @(posedge CLK)
  begin
    if (state == st_data_read && rx_done)
      rdata <= rx_byte;
  end

endmodule

/* logic/eeprom_wr.sv */
module eeprom_wr
  import eeprom_pkg::*;
(
  input  logic              CLK,
  input  logic              RESET,
  input  logic              wr,
  input  logic              rd,
  input  logic [ADDR_W-1:0] addr,
  input  logic [BYTE_W-1:0] wdata,
  output logic              ack,
  output logic [BYTE_W-1:0] rdata,
  output logic              SCL,
  inout  wire               SDA
);

  logic              cond_start;
  logic              cond_stop;
  logic              cond_done;
  logic              tx_active;
  logic              rx_active;
  logic              tx_load;
  logic [BYTE_W-1:0] tx_byte;
  logic              tx_bit;
  logic              tx_done;
  logic              rx_start;
  logic              rx_done;
  logic [BYTE_W-1:0] rx_byte;

  eeprom_sequencer u_sequencer (
    .CLK        (CLK),
    .RESET      (RESET),
    .wr         (wr),
    .rd         (rd),
    .addr       (addr),
    .wdata      (wdata),
    .cond_done  (cond_done),
    .tx_done    (tx_done),
    .rx_done    (rx_done),
    .rx_byte    (rx_byte),
    .SCL        (SCL),
    .ack        (ack),
    .rdata      (rdata),
    .cond_start (cond_start),
    .cond_stop  (cond_stop),
    .tx_active  (tx_active),
    .rx_active  (rx_active),
    .tx_load    (tx_load),
    .tx_byte    (tx_byte),
    .rx_start   (rx_start)
  );

  byte_transmitter u_transmitter (
    .CLK     (CLK),
    .RESET   (RESET),
    .SCL     (SCL),
    .tx_load (tx_load),
    .tx_byte (tx_byte),
    .tx_bit  (tx_bit),
    .tx_done (tx_done)
  );

  byte_receiver u_receiver (
    .CLK      (CLK),
    .RESET    (RESET),
    .SCL      (SCL),
    .SDA      (SDA),
    .rx_start (rx_start),
    .rx_byte  (rx_byte),
    .rx_done  (rx_done)
  );

  sda_line_driver u_line_driver (
    .CLK        (CLK),
    .RESET      (RESET),
    .SCL        (SCL),
    .cond_start (cond_start),
    .cond_stop  (cond_stop),
    .tx_active  (tx_active),
    .rx_active  (rx_active),
    .tx_bit     (tx_bit),
    .cond_done  (cond_done),
    .SDA        (SDA)
  );

endmodule

/* verification/eeprom_slave_model.sv */
module eeprom_slave_model
  import eeprom_pkg::*;
(
  input logic SCL,
  inout wire  SDA
);

  timeunit 1ns;
  timeprecision 1ps;

  logic [BYTE_W-1:0] mem [0:(1<<ADDR_W)-1];
  select_byte_u      last_select;
  int                frame_count;
  int                error_count;

  logic              in_frame   = 1'b0;
  logic              listening  = 1'b0; // master owns SDA
  logic              frame_read = 1'b0;
  logic              read_armed = 1'b0;
  logic              sending    = 1'b0;
  logic              read_done  = 1'b0;
  logic              drive_low  = 1'b0;
  logic [3:0]        bit_cnt;
  int                byte_cnt;
  int                sent;
  logic [BYTE_W-1:0] shift_in;
  logic [BYTE_W-1:0] shift_out;
  logic [ADDR_W-1:0] addr_ptr;
  logic [BYTE_W-1:0] data_in;

  assign SDA = drive_low ? 1'b0 : 1'bz; // open drain

  function automatic logic [BYTE_W-1:0] preset_byte(input logic [ADDR_W-1:0] a);
    return a[7:0] ^ {a[10:8], 5'b10110};
  endfunction

  initial
  begin
    frame_count = 0;
    error_count = 0;
    for (int i = 0; i < (1 << ADDR_W); i++)
      mem[i] = preset_byte(ADDR_W'(i));
  end

  // start or repeated start
  always @(negedge SDA)
  begin
    if (SCL === 1'b1)
    begin
      frame_count = frame_count + 1;
      in_frame    = 1'b1;
      listening   = 1'b1;
      frame_read  = 1'b0;
      read_armed  = 1'b0;
      sending     = 1'b0;
      read_done   = 1'b0;
      bit_cnt     = '0;
      byte_cnt    = 0;
    end
  end

  // stop
  always @(posedge SDA)
  begin
    if (SCL === 1'b1 && in_frame)
    begin
      if (frame_read ? !read_done : byte_cnt < 3)
        error_count = error_count + 1; // frame cut short
      else if (!frame_read)
        mem[addr_ptr] = data_in;
      in_frame  = 1'b0;
      listening = 1'b0;
    end
  end

  always @(posedge SCL)
  begin
    if (in_frame && listening)
    begin
      if (bit_cnt < BYTE_W)
      begin
        shift_in = {shift_in[BYTE_W-2:0], SDA};
        bit_cnt  = bit_cnt + 1'b1;
        if (bit_cnt == BYTE_W)
        begin
          if (byte_cnt == 0)
          begin
            last_select.raw = shift_in;
            frame_read      = last_select.fields.read_flag;
            if (last_select.fields.device_code != DEVICE_CODE)
              error_count = error_count + 1;
          end
          else if (byte_cnt == 1)
            addr_ptr = {last_select.fields.block, shift_in};
          else if (byte_cnt == 2)
            data_in = shift_in;
          byte_cnt = byte_cnt + 1;
        end
      end
      else
      begin
        bit_cnt = '0; // ack slot, left high
        if (frame_read)
        begin
          listening  = 1'b0;
          read_armed = 1'b1;
        end
      end
    end
  end

  // read data changes on SCL falling edges
  always @(negedge SCL)
  begin
    if (read_armed)
    begin
      read_armed = 1'b0;
      sending    = 1'b1;
      shift_out  = mem[addr_ptr];
      sent       = 0;
    end
    if (sending)
    begin
      if (sent < BYTE_W)
      begin
        drive_low = !shift_out[BYTE_W-1];
        shift_out = {shift_out[BYTE_W-2:0], 1'b1};
        sent      = sent + 1;
      end
      else
      begin
        drive_low = 1'b0; // release for the stop
        sending   = 1'b0;
        read_done = 1'b1;
      end
    end
  end

endmodule

/* verification/eeprom_wr_tb.sv */
module eeprom_wr_tb
  import eeprom_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam time CLK_PERIOD   = 20ns;
  localparam int  RESET_CYCLES = 8;
  localparam int  SEED         = 32'h684f;
  localparam int  NUM_OPS      = 24;
  localparam int  WAIT_LIMIT   = 400;

  logic              CLK;
  logic              RESET;
  logic              wr;
  logic              rd;
  logic [ADDR_W-1:0] addr;
  logic [BYTE_W-1:0] wdata;
  logic              ack;
  logic [BYTE_W-1:0] rdata;
  logic              SCL;
  wire               SDA;

  logic [BYTE_W-1:0] ref_mem [0:(1<<ADDR_W)-1];
  logic [ADDR_W-1:0] written [$];
  integer            seed;
  int                checks;
  int                errors;
  int                ack_count;
  int                ops_issued;
  int                frames_expected;
  bit                hung;

  pullup (SDA);

  eeprom_wr UUT (
    .CLK   (CLK),
    .RESET (RESET),
    .wr    (wr),
    .rd    (rd),
    .addr  (addr),
    .wdata (wdata),
    .ack   (ack),
    .rdata (rdata),
    .SCL   (SCL),
    .SDA   (SDA)
  );

  eeprom_slave_model u_eeprom (
    .SCL (SCL),
    .SDA (SDA)
  );

  initial
  begin
    CLK = 1'b0;
    forever #(CLK_PERIOD / 2) CLK = ~CLK;
  end

  always @(negedge CLK)
  begin
    if (!RESET && ack === 1'b1)
      ack_count++;
  end

  function automatic logic [BYTE_W-1:0] fill_value(input logic [ADDR_W-1:0] a);
    return a[7:0] ^ {a[10:8], 5'b10110}; // slave preset contents
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (expected !== actual)
    begin
      errors++;
      $display("[FAIL] %s: expected %0h, actual %0h", name, expected, actual);
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    $display("test %s finished, %0d errors", name, errors - errors_before);
  endtask

  task automatic run_op(input bit is_read, input logic [ADDR_W-1:0] a,
                        input logic [BYTE_W-1:0] d, input bit poke);
    int waited;
    @(posedge CLK);
    addr  <= a;
    wdata <= d;
    wr    <= !is_read;
    rd    <= is_read;
    @(posedge CLK);
    wr <= 1'b0;
    rd <= 1'b0;
    if (poke)
    begin
      repeat (12)
      begin
        @(posedge CLK);
        wr <= 1'($random(seed)); // must be ignored while busy
        rd <= 1'($random(seed));
      end
      @(posedge CLK);
      wr <= 1'b0;
      rd <= 1'b0;
    end
    ops_issued++;
    frames_expected += is_read ? 2 : 1;
    waited = 0;
    @(negedge CLK);
    while (ack !== 1'b1 && waited < WAIT_LIMIT)
    begin
      @(negedge CLK);
      waited++;
    end
    if (ack !== 1'b1)
    begin
      hung = 1'b1;
      $display("timeout: %s at address %0h got no ack, sequencer stuck in %s",
               is_read ? "read" : "write", a, UUT.u_sequencer.state.name());
    end
  endtask

  initial
  begin
    logic [ADDR_W-1:0] a;
    logic [BYTE_W-1:0] d;
    bit                op_rd;
    int                errors_before;
    seed  = SEED;
    RESET = 1'b1;
    wr    = 1'b0;
    rd    = 1'b0;
    addr  = '0;
    wdata = '0;
    for (int i = 0; i < (1 << ADDR_W); i++)
      ref_mem[i] = fill_value(ADDR_W'(i));

    repeat (RESET_CYCLES) @(posedge CLK);
    RESET <= 1'b0;
    #1;
    errors_before = errors;
    check_value("reset_state ack", 0, ack);
    check_value("reset_state SCL", 0, SCL);
    check_value("reset_state SDA", 1, SDA);
    report_test("reset_state", errors_before);

    errors_before = errors;
    for (int i = 0; i < NUM_OPS && !hung; i++)
    begin
      a = ADDR_W'($random(seed));
      d = BYTE_W'($random(seed));
      run_op(1'b0, a, d, 1'b0);
      if (!hung)
      begin
        ref_mem[a] = d;
        written.push_back(a);
        check_value("random_writes memory", d, u_eeprom.mem[a]);
        check_value("random_writes framing", 0, u_eeprom.error_count);
      end
    end
    report_test("random_writes", errors_before);

    errors_before = errors;
    for (int i = 0; i < NUM_OPS && !hung; i++)
    begin
      if (i % 2 == 0)
        a = written[$unsigned($random(seed)) % written.size()];
      else
        a = ADDR_W'($random(seed)); // mostly unwritten, preset fill
      run_op(1'b1, a, 8'h00, 1'b0);
      if (!hung)
        check_value("read_back rdata", ref_mem[a], rdata);
    end
    report_test("read_back", errors_before);

    errors_before = errors;
    for (int i = 0; i < 8 && !hung; i++)
    begin
      a     = ADDR_W'($random(seed));
      d     = BYTE_W'($random(seed));
      op_rd = i[0];
      run_op(op_rd, a, d, 1'b0);
      if (!hung)
      begin
        if (!op_rd)
          ref_mem[a] = d;
        check_value("select_byte device code", DEVICE_CODE,
                    u_eeprom.last_select.fields.device_code);
        check_value("select_byte block", a[ADDR_W-1:BYTE_W],
                    u_eeprom.last_select.fields.block);
        check_value("select_byte read flag", op_rd, u_eeprom.last_select.fields.read_flag);
      end
    end
    report_test("select_byte", errors_before);

    errors_before = errors;
    for (int i = 0; i < 8 && !hung; i++)
    begin
      a     = ADDR_W'($random(seed));
      d     = BYTE_W'($random(seed));
      op_rd = 1'($random(seed));
      run_op(op_rd, a, d, 1'b1);
      if (!hung && op_rd)
        check_value("busy_requests rdata", ref_mem[a], rdata);
      else if (!hung)
        ref_mem[a] = d;
    end
    if (!hung)
    begin
      repeat (WAIT_LIMIT) @(posedge CLK); // room for any stray operation
      check_value("busy_requests ack count", ops_issued, ack_count);
      check_value("busy_requests frame count", frames_expected, u_eeprom.frame_count);
      check_value("busy_requests framing", 0, u_eeprom.error_count);
    end
    report_test("busy_requests", errors_before);

    $display("closing: %0d checks, %0d errors, %0d operations, %0d acks",
             checks, errors, ops_issued, ack_count);
    if (errors == 0 && !hung)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

endmodule

/* eeprom_wr.f */
common/eeprom_pkg.sv
serial/byte_transmitter.sv
serial/byte_receiver.sv
serial/sda_line_driver.sv
logic/eeprom_sequencer.sv
logic/eeprom_wr.sv
verification/eeprom_slave_model.sv
verification/eeprom_wr_tb.sv
